// File: src/reduction_defines.svh
// Global sizing for the reduction offload block
// RED_TAG_WIDTH must hold a port index, so keep it at $clog2(RED_NUM_PORTS)
// The ALU computes on 32 bits whatever RED_DATA_WIDTH is set to

`ifndef REDUCTION_DEFINES_SVH
`define REDUCTION_DEFINES_SVH

// Number of reduction collectors sharing the ALU
`define RED_NUM_PORTS 2

// Element and result width
`define RED_DATA_WIDTH 64

// Port index carried with each ALU request
`define RED_TAG_WIDTH 1

`endif

// File: src/reduction_pkg.sv
// Types shared by the reduction offload block
// Collective opcodes 6 and 7 are unused and decode as RED_ADD in the ALU
// Only 32-bit integer formats exist

package reduction_pkg;

  // --------------------------------------------------------------------
  // Opcode carried with every element
  // --------------------------------------------------------------------
  typedef enum logic [2:0] {
    RED_ADD   = 3'd0,
    RED_MUL   = 3'd1,
    RED_MIN_S = 3'd2,
    RED_MIN_U = 3'd3,
    RED_MAX_S = 3'd4,
    RED_MAX_U = 3'd5
  } collect_op_e;

  // --------------------------------------------------------------------
  // Internal ALU operation and format
  // --------------------------------------------------------------------
  typedef enum logic [1:0] {
    ADD = 2'd0,
    MUL = 2'd1,
    MIN = 2'd2,
    MAX = 2'd3
  } alu_op_e;

  // Format only matters for MIN and MAX
  typedef enum logic {
    INT32  = 1'b0,
    UINT32 = 1'b1
  } alu_fmt_e;

  // --------------------------------------------------------------------
  // Collector FSM
  // --------------------------------------------------------------------
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    WAIT_ELEM   = 2'd1,
    WAIT_ALU    = 2'd2,
    HOLD_RESULT = 2'd3
  } collector_state_e;

endpackage

// File: src/reduction_alu.sv
// Shared integer ALU with a two-entry output buffer
// Only the low 32 bits of each operand are used, result is sign-extended
// Up to two requests can be in flight, req_ready_o drops when both slots hold data
// flush_i drops every buffered result on the next edge

`timescale 1ns/1ps
`include "reduction_defines.svh"

module reduction_alu (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic [`RED_DATA_WIDTH-1:0] req_op_a_i,
  input  logic [`RED_DATA_WIDTH-1:0] req_op_b_i,
  input  reduction_pkg::collect_op_e req_op_i,
  input  logic [`RED_TAG_WIDTH-1:0]  req_tag_i,
  output logic                       resp_valid_o,
  output logic [`RED_DATA_WIDTH-1:0] resp_data_o,
  output logic [`RED_TAG_WIDTH-1:0]  resp_tag_o,
  input  logic                       resp_ready_i
);
  import reduction_pkg::*;

  alu_op_e                    alu_op;
  alu_fmt_e                   alu_fmt;
  logic [31:0]                a32;
  logic [31:0]                b32;
  logic [32:0]                a_cmp;
  logic [32:0]                b_cmp;
  logic                       a_gt_b;
  logic [31:0]                res_32;
  logic [`RED_DATA_WIDTH-1:0] res_ext;

  // Output buffer, two slots used as a tiny FIFO
  logic [`RED_DATA_WIDTH-1:0] slot_data_q [2];
  logic [`RED_TAG_WIDTH-1:0]  slot_tag_q  [2];
  logic                       wr_ptr_q;
  logic                       rd_ptr_q;
  logic [1:0]                 count_q;
  logic                       push;
  logic                       pop;

  // --------------------------------------------------------------------
  // Opcode decode
  // --------------------------------------------------------------------
  always_comb begin
    alu_op  = ADD;
    alu_fmt = INT32;
    case (req_op_i)
      RED_MUL:   alu_op = MUL;
      RED_MIN_S: alu_op = MIN;
      RED_MIN_U: begin
        alu_op  = MIN;
        alu_fmt = UINT32;
      end
      RED_MAX_S: alu_op = MAX;
      RED_MAX_U: begin
        alu_op  = MAX;
        alu_fmt = UINT32;
      end
      // RED_ADD and the two unused codes
      default:   alu_op = ADD;
    endcase
  end

  // --------------------------------------------------------------------
  // Datapath
  // --------------------------------------------------------------------
  assign a32 = req_op_a_i[31:0];
  assign b32 = req_op_b_i[31:0];

  // Extra top bit is the sign for INT32 and zero for UINT32,
  // so one signed comparator covers both formats
  assign a_cmp  = {(alu_fmt == INT32) & a32[31], a32};
  assign b_cmp  = {(alu_fmt == INT32) & b32[31], b32};
  assign a_gt_b = $signed(a_cmp) > $signed(b_cmp);

  always_comb begin
    case (alu_op)
      MUL:     res_32 = a32 * b32;
      MIN:     res_32 = a_gt_b ? b32 : a32;
      MAX:     res_32 = a_gt_b ? a32 : b32;
      default: res_32 = a32 + b32;
    endcase
  end

  assign res_ext = {{(`RED_DATA_WIDTH-32){res_32[31]}}, res_32};

  // --------------------------------------------------------------------
  // Output buffer
  // --------------------------------------------------------------------
  assign req_ready_o  = (count_q != 2'd2);
  assign resp_valid_o = (count_q != 2'd0);
  assign push         = req_valid_i && req_ready_o;
  assign pop          = resp_valid_o && resp_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else if (flush_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push) wr_ptr_q <= ~wr_ptr_q;
      if (pop)  rd_ptr_q <= ~rd_ptr_q;
      // Occupancy only moves when exactly one side fires
      case ({push, pop})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  // Result and tag storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      slot_data_q[wr_ptr_q] <= res_ext;
      slot_tag_q[wr_ptr_q]  <= req_tag_i;
    end
  end

  assign resp_data_o = slot_data_q[rd_ptr_q];
  assign resp_tag_o  = slot_tag_q[rd_ptr_q];

endmodule

// File: src/alu_arbiter.sv
// Round-robin access from the collectors to the shared ALU
// Purely combinational request path, only the pointer is registered
// Responses go back to the port named by the returned tag

`timescale 1ns/1ps
`include "reduction_defines.svh"

module alu_arbiter (
  input  logic                                             clk_i,
  input  logic                                             rst_n_i,
  input  logic                                             flush_i,
  // Collector side
  input  logic [`RED_NUM_PORTS-1:0]                        col_req_valid_i,
  output logic [`RED_NUM_PORTS-1:0]                        col_req_ready_o,
  input  logic [`RED_NUM_PORTS-1:0][`RED_DATA_WIDTH-1:0]   col_op_a_i,
  input  logic [`RED_NUM_PORTS-1:0][`RED_DATA_WIDTH-1:0]   col_op_b_i,
  input  reduction_pkg::collect_op_e [`RED_NUM_PORTS-1:0]  col_op_i,
  output logic [`RED_NUM_PORTS-1:0]                        col_resp_valid_o,
  input  logic [`RED_NUM_PORTS-1:0]                        col_resp_ready_i,
  output logic [`RED_DATA_WIDTH-1:0]                       col_resp_data_o,
  // ALU side
  output logic                                             alu_req_valid_o,
  input  logic                                             alu_req_ready_i,
  output logic [`RED_DATA_WIDTH-1:0]                       alu_op_a_o,
  output logic [`RED_DATA_WIDTH-1:0]                       alu_op_b_o,
  output reduction_pkg::collect_op_e                       alu_op_o,
  output logic [`RED_TAG_WIDTH-1:0]                        alu_tag_o,
  input  logic                                             alu_resp_valid_i,
  input  logic [`RED_DATA_WIDTH-1:0]                       alu_resp_data_i,
  input  logic [`RED_TAG_WIDTH-1:0]                        alu_resp_tag_i,
  output logic                                             alu_resp_ready_o
);
  import reduction_pkg::*;

  logic [`RED_TAG_WIDTH-1:0] rr_q;
  logic [`RED_TAG_WIDTH-1:0] sel;
  logic                      found;

  // --------------------------------------------------------------------
  // Request selection
  // --------------------------------------------------------------------
  // Scan from the pointer, first valid port wins
  always_comb begin
    int unsigned cand;
    sel   = rr_q;
    found = 1'b0;
    for (int k = 0; k < `RED_NUM_PORTS; k++) begin
      cand = (int'(rr_q) + k) % `RED_NUM_PORTS;
      if (!found && col_req_valid_i[cand]) begin
        sel   = `RED_TAG_WIDTH'(cand);
        found = 1'b1;
      end
    end
  end

  // Valid never looks at ready, only the granted port sees ready
  always_comb begin
    alu_req_valid_o = found;
    alu_tag_o       = sel;
    alu_op_a_o      = '0;
    alu_op_b_o      = '0;
    alu_op_o        = RED_ADD;
    if (found) begin
      alu_op_a_o = col_op_a_i[sel];
      alu_op_b_o = col_op_b_i[sel];
      alu_op_o   = col_op_i[sel];
    end
    for (int p = 0; p < `RED_NUM_PORTS; p++) begin
      col_req_ready_o[p] = found && alu_req_ready_i && (sel == `RED_TAG_WIDTH'(p));
    end
  end

  // Pointer moves one past the granted port after each transfer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rr_q <= '0;
    end else if (flush_i) begin
      rr_q <= '0;
    end else if (alu_req_valid_o && alu_req_ready_i) begin
      rr_q <= (sel == `RED_TAG_WIDTH'(`RED_NUM_PORTS-1)) ? '0 : sel + 1'b1;
    end
  end

  // --------------------------------------------------------------------
  // Response steering by tag
  // --------------------------------------------------------------------
  always_comb begin
    for (int p = 0; p < `RED_NUM_PORTS; p++) begin
      col_resp_valid_o[p] = alu_resp_valid_i && (alu_resp_tag_i == `RED_TAG_WIDTH'(p));
    end
  end

  assign col_resp_data_o  = alu_resp_data_i;
  assign alu_resp_ready_o = col_resp_ready_i[alu_resp_tag_i];

endmodule

// File: src/reduction_collector.sv
// Folds one element stream into a running value through the shared ALU
// The opcode of the first element applies to the whole reduction
// One ALU request in flight per collector
// Elements offered while flush_i is high are dropped

`timescale 1ns/1ps
`include "reduction_defines.svh"

module reduction_collector (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       flush_i,
  // Element stream
  input  logic                       elem_valid_i,
  input  logic [`RED_DATA_WIDTH-1:0] elem_data_i,
  input  reduction_pkg::collect_op_e elem_op_i,
  input  logic                       elem_last_i,
  output logic                       elem_ready_o,
  // Result stream
  output logic                       res_valid_o,
  output logic [`RED_DATA_WIDTH-1:0] res_data_o,
  input  logic                       res_ready_i,
  // Toward the arbiter
  output logic                       alu_req_valid_o,
  input  logic                       alu_req_ready_i,
  output logic [`RED_DATA_WIDTH-1:0] alu_op_a_o,
  output logic [`RED_DATA_WIDTH-1:0] alu_op_b_o,
  output reduction_pkg::collect_op_e alu_op_o,
  input  logic                       alu_resp_valid_i,
  input  logic [`RED_DATA_WIDTH-1:0] alu_resp_data_i,
  output logic                       alu_resp_ready_o
);
  import reduction_pkg::*;

  collector_state_e           state_q;
  collector_state_e           state_d;
  // High once the pending request has left for the ALU
  logic                       req_sent_q;
  logic                       req_sent_d;

  logic [`RED_DATA_WIDTH-1:0] acc_q;
  collect_op_e                op_q;
  logic [`RED_DATA_WIDTH-1:0] pend_q;
  logic                       pend_last_q;

  logic                       elem_fire;
  logic                       req_fire;
  logic                       resp_fire;
  logic                       res_fire;

  assign elem_fire = elem_valid_i && elem_ready_o;
  assign req_fire  = alu_req_valid_o && alu_req_ready_i;
  assign resp_fire = alu_resp_valid_i && alu_resp_ready_o;
  assign res_fire  = res_valid_o && res_ready_i;

  // --------------------------------------------------------------------
  // FSM
  // --------------------------------------------------------------------
  always_comb begin
    state_d    = state_q;
    req_sent_d = req_sent_q;
    case (state_q)
      IDLE: begin
        // Single-element reduction goes straight to the result
        if (elem_fire) state_d = elem_last_i ? HOLD_RESULT : WAIT_ELEM;
      end
      WAIT_ELEM: begin
        if (elem_fire) state_d = WAIT_ALU;
      end
      WAIT_ALU: begin
        if (req_fire) req_sent_d = 1'b1;
        if (resp_fire) begin
          req_sent_d = 1'b0;
          state_d    = pend_last_q ? HOLD_RESULT : WAIT_ELEM;
        end
      end
      HOLD_RESULT: begin
        if (res_fire) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
    if (flush_i) begin
      state_d    = IDLE;
      req_sent_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= IDLE;
      req_sent_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      req_sent_q <= req_sent_d;
    end
  end

  // --------------------------------------------------------------------
  // Accumulator and pending element
  // --------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    // First element seeds the accumulator and fixes the opcode
    if (state_q == IDLE && elem_fire) begin
      acc_q <= elem_data_i;
      op_q  <= elem_op_i;
    end else if (resp_fire) begin
      acc_q <= alu_resp_data_i;
    end
    if (state_q == WAIT_ELEM && elem_fire) begin
      pend_q      <= elem_data_i;
      pend_last_q <= elem_last_i;
    end
  end

  // --------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------
  assign elem_ready_o     = (state_q == IDLE) || (state_q == WAIT_ELEM);
  assign res_valid_o      = (state_q == HOLD_RESULT);
  assign res_data_o       = acc_q;
  assign alu_req_valid_o  = (state_q == WAIT_ALU) && !req_sent_q;
  assign alu_resp_ready_o = (state_q == WAIT_ALU) && req_sent_q;
  assign alu_op_a_o       = acc_q;
  assign alu_op_b_o       = pend_q;
  assign alu_op_o         = op_q;

endmodule

// File: src/reduction_unit.sv
// Reduction offload block, collectors share one integer ALU
// Each port carries its own element and result stream
// flush_i clears all collectors and the ALU buffer

`timescale 1ns/1ps
`include "reduction_defines.svh"

module reduction_unit (
  input  logic                                            clk_i,
  input  logic                                            rst_n_i,
  input  logic                                            flush_i,
  input  logic [`RED_NUM_PORTS-1:0]                       elem_valid_i,
  input  logic [`RED_NUM_PORTS-1:0][`RED_DATA_WIDTH-1:0]  elem_data_i,
  input  reduction_pkg::collect_op_e [`RED_NUM_PORTS-1:0] elem_op_i,
  input  logic [`RED_NUM_PORTS-1:0]                       elem_last_i,
  output logic [`RED_NUM_PORTS-1:0]                       elem_ready_o,
  output logic [`RED_NUM_PORTS-1:0]                       res_valid_o,
  output logic [`RED_NUM_PORTS-1:0][`RED_DATA_WIDTH-1:0]  res_data_o,
  input  logic [`RED_NUM_PORTS-1:0]                       res_ready_i
);

  // Collector to arbiter
  logic [`RED_NUM_PORTS-1:0]                       col_req_valid;
  logic [`RED_NUM_PORTS-1:0]                       col_req_ready;
  logic [`RED_NUM_PORTS-1:0][`RED_DATA_WIDTH-1:0]  col_op_a;
  logic [`RED_NUM_PORTS-1:0][`RED_DATA_WIDTH-1:0]  col_op_b;
  reduction_pkg::collect_op_e [`RED_NUM_PORTS-1:0] col_op;
  logic [`RED_NUM_PORTS-1:0]                       col_resp_valid;
  logic [`RED_NUM_PORTS-1:0]                       col_resp_ready;
  logic [`RED_DATA_WIDTH-1:0]                      col_resp_data;

  // Arbiter to ALU
  logic                       alu_req_valid;
  logic                       alu_req_ready;
  logic [`RED_DATA_WIDTH-1:0] alu_op_a;
  logic [`RED_DATA_WIDTH-1:0] alu_op_b;
  reduction_pkg::collect_op_e alu_op;
  logic [`RED_TAG_WIDTH-1:0]  alu_tag;
  logic                       alu_resp_valid;
  logic [`RED_DATA_WIDTH-1:0] alu_resp_data;
  logic [`RED_TAG_WIDTH-1:0]  alu_resp_tag;
  logic                       alu_resp_ready;

  // --------------------------------------------------------------------
  // One collector per port
  // --------------------------------------------------------------------
  for (genvar p = 0; p < `RED_NUM_PORTS; p++) begin : gen_collector
    reduction_collector u_collector (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .flush_i          (flush_i),
      .elem_valid_i     (elem_valid_i[p]),
      .elem_data_i      (elem_data_i[p]),
      .elem_op_i        (elem_op_i[p]),
      .elem_last_i      (elem_last_i[p]),
      .elem_ready_o     (elem_ready_o[p]),
      .res_valid_o      (res_valid_o[p]),
      .res_data_o       (res_data_o[p]),
      .res_ready_i      (res_ready_i[p]),
      .alu_req_valid_o  (col_req_valid[p]),
      .alu_req_ready_i  (col_req_ready[p]),
      .alu_op_a_o       (col_op_a[p]),
      .alu_op_b_o       (col_op_b[p]),
      .alu_op_o         (col_op[p]),
      .alu_resp_valid_i (col_resp_valid[p]),
      .alu_resp_data_i  (col_resp_data),
      .alu_resp_ready_o (col_resp_ready[p])
    );
  end

  alu_arbiter u_arbiter (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .flush_i          (flush_i),
    .col_req_valid_i  (col_req_valid),
    .col_req_ready_o  (col_req_ready),
    .col_op_a_i       (col_op_a),
    .col_op_b_i       (col_op_b),
    .col_op_i         (col_op),
    .col_resp_valid_o (col_resp_valid),
    .col_resp_ready_i (col_resp_ready),
    .col_resp_data_o  (col_resp_data),
    .alu_req_valid_o  (alu_req_valid),
    .alu_req_ready_i  (alu_req_ready),
    .alu_op_a_o       (alu_op_a),
    .alu_op_b_o       (alu_op_b),
    .alu_op_o         (alu_op),
    .alu_tag_o        (alu_tag),
    .alu_resp_valid_i (alu_resp_valid),
    .alu_resp_data_i  (alu_resp_data),
    .alu_resp_tag_i   (alu_resp_tag),
    .alu_resp_ready_o (alu_resp_ready)
  );

  reduction_alu u_alu (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .req_valid_i  (alu_req_valid),
    .req_ready_o  (alu_req_ready),
    .req_op_a_i   (alu_op_a),
    .req_op_b_i   (alu_op_b),
    .req_op_i     (alu_op),
    .req_tag_i    (alu_tag),
    .resp_valid_o (alu_resp_valid),
    .resp_data_o  (alu_resp_data),
    .resp_tag_o   (alu_resp_tag),
    .resp_ready_i (alu_resp_ready)
  );

endmodule

// File: tb/tb_reduction_unit.sv
// Table-driven testbench for the reduction unit
// Expected results come from a reference fold of the 32-bit integer rules
// Rows flagged as paired run at the same time on both ports
// Inputs change 2 ns after the rising edge and outputs are sampled at the falling edge

`timescale 1ns/1ps
`include "reduction_defines.svh"

module tb_reduction_unit;
  import reduction_pkg::*;

  localparam int MAX_CASES = 16;
  localparam int TIMEOUT   = 200;

  logic                                            clk;
  logic                                            rst_n;
  logic                                            flush;
  logic [`RED_NUM_PORTS-1:0]                       elem_valid;
  logic [`RED_NUM_PORTS-1:0][`RED_DATA_WIDTH-1:0]  elem_data;
  collect_op_e [`RED_NUM_PORTS-1:0]                elem_op;
  logic [`RED_NUM_PORTS-1:0]                       elem_last;
  logic [`RED_NUM_PORTS-1:0]                       elem_ready;
  logic [`RED_NUM_PORTS-1:0]                       res_valid;
  logic [`RED_NUM_PORTS-1:0][`RED_DATA_WIDTH-1:0]  res_data;
  logic [`RED_NUM_PORTS-1:0]                       res_ready;

  // --------------------------------------------------------------------
  // Case table
  // --------------------------------------------------------------------
  string       name_t  [MAX_CASES];
  int          port_t  [MAX_CASES];
  collect_op_e op_t    [MAX_CASES];
  int          cnt_t   [MAX_CASES];
  bit          bp_t    [MAX_CASES];
  bit          pair_t  [MAX_CASES];
  // Number of elements sent ahead of a flush, or 0 for no flush
  int          flush_t [MAX_CASES];
  logic [63:0] elem_t  [MAX_CASES][5];
  int          n_cases;

  logic [31:0] rng_state;
  int          check_count;
  int          err_count;
  int          timeout_count;

  reduction_unit uut (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .flush_i      (flush),
    .elem_valid_i (elem_valid),
    .elem_data_i  (elem_data),
    .elem_op_i    (elem_op),
    .elem_last_i  (elem_last),
    .elem_ready_o (elem_ready),
    .res_valid_o  (res_valid),
    .res_data_o   (res_data),
    .res_ready_i  (res_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift(rng_state);
    return rng_state;
  endfunction

  // Opcode for later elements that the collector must ignore
  function automatic collect_op_e other_op(input collect_op_e op);
    return (op == RED_MAX_U) ? RED_ADD : collect_op_e'(op + 3'd1);
  endfunction

  task automatic add_case(input string nm, input int port, input collect_op_e op,
                          input int cnt, input bit rnd, input bit bp, input bit pair,
                          input int flush_at, input logic [63:0] e0, input logic [63:0] e1,
                          input logic [63:0] e2, input logic [63:0] e3,
                          input logic [63:0] e4);
    logic [31:0] hi;
    logic [31:0] lo;
    name_t[n_cases]    = nm;
    port_t[n_cases]    = port;
    op_t[n_cases]      = op;
    cnt_t[n_cases]     = cnt;
    bp_t[n_cases]      = bp;
    pair_t[n_cases]    = pair;
    flush_t[n_cases]   = flush_at;
    elem_t[n_cases][0] = e0;
    elem_t[n_cases][1] = e1;
    elem_t[n_cases][2] = e2;
    elem_t[n_cases][3] = e3;
    elem_t[n_cases][4] = e4;
    // Random elements fill all 64 bits so the upper half is exercised
    if (rnd) begin
      for (int k = 0; k < 5; k++) begin
        hi = next_random();
        lo = next_random();
        elem_t[n_cases][k] = {hi, lo};
      end
    end
    n_cases++;
  endtask

  // Reference fold with a 32-bit operation and sign extension at each step
  function automatic logic [63:0] fold_ref(input int i);
    logic [63:0] acc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    acc = elem_t[i][0];
    for (int k = 1; k < cnt_t[i]; k++) begin
      a = acc[31:0];
      b = elem_t[i][k][31:0];
      case (op_t[i])
        RED_MUL:   r = a * b;
        RED_MIN_S: r = ($signed(a) < $signed(b)) ? a : b;
        RED_MIN_U: r = (a < b) ? a : b;
        RED_MAX_S: r = ($signed(a) > $signed(b)) ? a : b;
        RED_MAX_U: r = (a > b) ? a : b;
        default:   r = a + b;
      endcase
      acc = {{32{r[31]}}, r};
    end
    return acc;
  endfunction

  // --------------------------------------------------------------------
  // Stream helpers that start and end 2 ns after a rising edge
  // --------------------------------------------------------------------
  task automatic send_elem(input int p, input logic [63:0] data, input collect_op_e op,
                           input logic last, input string nm);
    bit fired;
    int waited;
    fired         = 1'b0;
    waited        = 0;
    elem_valid[p] = 1'b1;
    elem_data[p]  = data;
    elem_op[p]    = op;
    elem_last[p]  = last;
    while (!fired && waited < TIMEOUT) begin
      @(negedge clk);
      if (elem_ready[p]) fired = 1'b1;
      @(posedge clk);
      #2;
      waited++;
    end
    elem_valid[p] = 1'b0;
    elem_last[p]  = 1'b0;
    if (!fired) begin
      $display("Timeout: port %0d never accepted an element in %s", p, nm);
      timeout_count++;
    end
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    @(posedge clk);
    #2;
    flush = 1'b0;
  endtask

  task automatic take_result(input int i, input logic [63:0] exp_val);
    int          p;
    int          waited;
    int          hold;
    p            = port_t[i];
    waited       = 0;
    res_ready[p] = !bp_t[i];
    @(negedge clk);
    while (!res_valid[p] && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    if (!res_valid[p]) begin
      $display("Timeout: no result on port %0d in %s", p, name_t[i]);
      timeout_count++;
      res_ready[p] = 1'b0;
      return;
    end
    check_count++;
    if (res_data[p] !== exp_val) begin
      $display("[ERROR] %s: expected %h, actual %h", name_t[i], exp_val, res_data[p]);
      err_count++;
    end
    // Hold the result back for a random stretch
    if (bp_t[i]) begin
      hold = int'(next_random() % 32'd6) + 1;
      repeat (hold) begin
        @(negedge clk);
        check_count++;
        if (!res_valid[p]) begin
          $display("Result valid dropped on port %0d before it was taken in %s", p, name_t[i]);
          err_count++;
        end
        if (res_data[p] !== exp_val) begin
          $display("[ERROR] %s hold: expected %h, actual %h", name_t[i], exp_val, res_data[p]);
          err_count++;
        end
        if (elem_ready[p]) begin
          $display("Port %0d ready for elements while holding a result in %s", p, name_t[i]);
          err_count++;
        end
      end
      @(posedge clk);
      #2;
      res_ready[p] = 1'b1;
      @(negedge clk);
    end
    @(posedge clk);
    #2;
    res_ready[p] = 1'b0;
  endtask

  task automatic run_case(input int i);
    int p;
    p = port_t[i];
    // Partial reduction that the flush must discard
    for (int k = 0; k < flush_t[i]; k++) begin
      send_elem(p, elem_t[i][k] ^ 64'h0000_0000_0F0F_0F0F, op_t[i], 1'b0, name_t[i]);
    end
    if (flush_t[i] > 0) pulse_flush();
    for (int k = 0; k < cnt_t[i]; k++) begin
      send_elem(p, elem_t[i][k], (k == 0) ? op_t[i] : other_op(op_t[i]),
                k == cnt_t[i] - 1, name_t[i]);
    end
    take_result(i, fold_ref(i));
  endtask

  // --------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------
  initial begin
    int i;
    rst_n         = 1'b0;
    flush         = 1'b0;
    elem_valid    = '0;
    elem_data     = '0;
    for (int p = 0; p < `RED_NUM_PORTS; p++) begin
      elem_op[p] = RED_ADD;
    end
    elem_last     = '0;
    res_ready     = '0;
    rng_state     = 32'h5aff3d3e;
    n_cases       = 0;
    check_count   = 0;
    err_count     = 0;
    timeout_count = 0;

    //       name  port op  cnt rnd bp pair flush elements
    add_case("add3", 0, RED_ADD, 3, 0, 0, 0, 0, 64'hFFFF_0000_0000_0005,
             64'h1234_5678_7FFF_FFFF, 64'h1, 64'h0, 64'h0);
    add_case("mul4", 1, RED_MUL, 4, 0, 0, 0, 0, 64'hAAAA_0000_0001_0003,
             64'h0000_FFFF_0000_0007, 64'h10000, 64'h1_0000_0010, 64'h0);
    add_case("add5_rand", 0, RED_ADD, 5, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_case("mul2_rand", 1, RED_MUL, 2, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_case("min_s", 0, RED_MIN_S, 3, 0, 0, 0, 0, 64'h8000_0000,
             64'hFFFF_FFFF, 64'h7FFF_FFFF, 64'h0, 64'h0);
    add_case("min_u", 1, RED_MIN_U, 3, 0, 0, 0, 0, 64'h8000_0000,
             64'hFFFF_FFFF, 64'h7FFF_FFFF, 64'h0, 64'h0);
    add_case("max_s", 0, RED_MAX_S, 3, 0, 0, 0, 0, 64'h8000_0000,
             64'hFFFF_FFFF, 64'h7FFF_FFFF, 64'h0, 64'h0);
    add_case("max_u", 1, RED_MAX_U, 3, 0, 0, 0, 0, 64'h7FFF_FFFF,
             64'hFFFF_FFFF, 64'h8000_0000, 64'h0, 64'h0);
    add_case("single", 1, RED_MUL, 1, 0, 0, 0, 0, 64'hDEAD_BEEF_1234_5678,
             64'h0, 64'h0, 64'h0, 64'h0);
    add_case("dual_p0", 0, RED_MAX_U, 5, 1, 0, 1, 0, 0, 0, 0, 0, 0);
    add_case("dual_p1", 1, RED_MUL, 5, 1, 0, 0, 0, 0, 0, 0, 0, 0);
    add_case("bp_add", 0, RED_ADD, 4, 1, 1, 0, 0, 0, 0, 0, 0, 0);
    add_case("bp_single", 1, RED_MIN_U, 1, 1, 1, 0, 0, 0, 0, 0, 0, 0);
    add_case("dual_bp_p0", 0, RED_MIN_S, 4, 1, 1, 1, 0, 0, 0, 0, 0, 0);
    add_case("dual_bp_p1", 1, RED_ADD, 3, 1, 1, 0, 0, 0, 0, 0, 0, 0);
    add_case("flush_mid", 0, RED_ADD, 4, 1, 0, 0, 2, 0, 0, 0, 0, 0);

    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(negedge clk);
    check_count++;
    if (elem_ready !== 2'b11 || res_valid !== 2'b00) begin
      $display("Wrong stream state after reset: elem_ready %b, res_valid %b",
               elem_ready, res_valid);
      err_count++;
    end
    @(posedge clk);
    #2;

    i = 0;
    while (i < n_cases) begin
      if (pair_t[i]) begin
        fork
          run_case(i);
          run_case(i + 1);
        join
        i += 2;
      end else begin
        run_case(i);
        i++;
      end
    end

    $display("Checks: %0d, errors: %0d, timeouts: %0d", check_count, err_count,
             timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: reduction_unit.f
+incdir+src
src/reduction_pkg.sv
src/reduction_alu.sv
src/alu_arbiter.sv
src/reduction_collector.sv
src/reduction_unit.sv
tb/tb_reduction_unit.sv

// File: run.sh
#!/bin/sh
# Compile and run the reduction unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f reduction_unit.f --top-module tb_reduction_unit -o sim_tb

out=$(./obj_dir/sim_tb)
echo "$out"

if echo "$out" | grep -q "^Everything OK$"; then
  exit 0
fi
exit 1
